//--- verilog/sram_pkg.sv
package sram_pkg;

    // halfword address bits on the SRAM pins
    localparam int unsigned sram_addr_width = 17;

    // bytes in the SRAM, two bytes per halfword address
    localparam logic [31:0] sram_byte_limit = 32'd1 << (sram_addr_width + 1);

    // wait counts inside the 32-bit timing control word
    localparam int unsigned wr_wait_lsb      = 0;  // write setup, we low before data is taken
    localparam int unsigned rd_wait_lsb      = 4;  // extra cycles before each read sample
    localparam int unsigned hold_wait_lsb    = 8;  // gap between the two write halves
    localparam int unsigned wait_field_width = 4;

    // round-robin arbiter states
    typedef enum logic [1:0]
    {
        arb_idle,
        arb_grant,
        arb_release
    } arb_state_t;

endpackage

//--- verilog/mem_req_if.sv
`timescale 1ns/1ps

// one memory request channel, req is held with stable fields until a one-cycle ack
interface mem_req_if;

    logic [31:0] addr;  // byte address
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        we;
    logic        req;
    logic [31:0] rdata;
    logic        ack;

    modport requester
    (
        output addr, wdata, strb, we, req,
        input  rdata, ack
    );

    modport server
    (
        input  addr, wdata, strb, we, req,
        output rdata, ack
    );

endinterface

//--- verilog/apb_mem_port.sv
`timescale 1ns/1ps

module apb_mem_port
    import sram_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         psel_i,
    input  logic         penable_i,
    input  logic         pwrite_i,
    input  logic [31:0]  paddr_i,
    input  logic [31:0]  pwdata_i,
    input  logic [3:0]   pstrb_i,
    output logic [31:0]  prdata_o,
    output logic         pready_o,
    output logic         pslverr_o,
    mem_req_if.requester mem
);

    logic        setup_phase;
    logic        req_q;
    logic        we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  strb_q;

    assign setup_phase = psel_i && !penable_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            req_q     <= 1'b0;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end
        else if (pready_o)
        begin
            // the master samples completion on this edge
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end
        else if (setup_phase)
        begin
            if (paddr_i >= sram_byte_limit)
            begin
                pready_o  <= 1'b1;  // error answered in the first access cycle
                pslverr_o <= 1'b1;
            end
            else
                req_q <= 1'b1;
        end
        else if (req_q && mem.ack)
        begin
            req_q    <= 1'b0;
            pready_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (setup_phase)
        begin
            addr_q  <= paddr_i;
            wdata_q <= pwdata_i;
            strb_q  <= pwrite_i ? pstrb_i : 4'b0000;  // zero strobes mark a read
            we_q    <= pwrite_i;
        end
        if (req_q && mem.ack && !we_q)
            prdata_o <= mem.rdata;
    end

    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;
    assign mem.strb  = strb_q;
    assign mem.we    = we_q;
    assign mem.req   = req_q;

    // the master keeps psel and penable up until it has seen pready
    a_pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        pready_o |-> psel_i && penable_i);

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import sram_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    mem_req_if.server    req0,
    mem_req_if.server    req1,
    mem_req_if.requester ctrl
);

    arb_state_t state_q;
    logic       sel_q;   // granted channel
    logic       last_q;  // channel served last
    logic       pick;

    // on a tie the channel not served last wins
    assign pick = (req0.req && req1.req) ? !last_q : req1.req;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q <= arb_idle;
            sel_q   <= 1'b0;
            last_q  <= 1'b1;  // port 0 goes first after reset
        end
        else
        begin
            case (state_q)
                arb_idle:
                begin
                    if (req0.req || req1.req)
                    begin
                        sel_q   <= pick;
                        state_q <= arb_grant;
                    end
                end
                arb_grant:
                begin
                    if (ctrl.ack)
                    begin
                        last_q  <= sel_q;
                        state_q <= arb_release;
                    end
                end
                // one cycle with no request so the controller cannot restart
                arb_release: state_q <= arb_idle;
                default:     state_q <= arb_idle;
            endcase
        end
    end

    assign ctrl.addr  = sel_q ? req1.addr : req0.addr;
    assign ctrl.wdata = sel_q ? req1.wdata : req0.wdata;
    assign ctrl.strb  = sel_q ? req1.strb : req0.strb;
    assign ctrl.we    = sel_q ? req1.we : req0.we;
    assign ctrl.req   = (state_q == arb_grant) && (sel_q ? req1.req : req0.req);

    assign req0.ack   = ctrl.ack && (state_q == arb_grant) && !sel_q;
    assign req1.ack   = ctrl.ack && (state_q == arb_grant) && sel_q;
    assign req0.rdata = sel_q ? 32'h0 : ctrl.rdata;
    assign req1.rdata = sel_q ? ctrl.rdata : 32'h0;

    // an ack from the controller only ever answers the granted, still waiting channel
    a_ack_to_granted: assert property (@(posedge clk_i) disable iff (rst_i)
        ctrl.ack |-> (state_q == arb_grant) && (sel_q ? req1.req : req0.req));

endmodule

//--- verilog/asram16_ctrl.sv
`timescale 1ns/1ps

module asram16_ctrl
    import sram_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [31:0]                timing_ctrl_i,
    output logic [sram_addr_width-1:0] sram_addr_o,
    output logic [15:0]                sram_data_o,
    input  logic [15:0]                sram_data_i,
    output logic                       sram_oe_o,
    output logic                       sram_we_o,
    output logic [1:0]                 sram_be_o,
    output logic                       sram_dir_out_o,
    mem_req_if.server                  mem
);

    typedef enum logic [3:0]
    {
        st_idle,
        st_wr_wait1,
        st_wr_data1,
        st_wr_hold,
        st_wr_setup2,
        st_wr_wait2,
        st_wr_data2,
        st_rd_wait1,
        st_rd_data1,
        st_rd_wait2,
        st_rd_data2
    } ctrl_state_t;

    ctrl_state_t                 state_q;
    ctrl_state_t                 wait_exit;
    logic [wait_field_width-1:0] wr_wait;
    logic [wait_field_width-1:0] rd_wait;
    logic [wait_field_width-1:0] hold_wait;
    logic [wait_field_width-1:0] wait_q;
    logic [sram_addr_width-2:0]  pair_q;    // halfword pair index of the word
    logic [15:0]                 wdata_lo_q;
    logic [3:0]                  strb_q;
    logic [15:0]                 rd_hi_q;
    logic [31:0]                 rdata_q;
    logic                        ack_q;
    logic                        accept;
    logic                        lower_only;

    assign wr_wait   = timing_ctrl_i[wr_wait_lsb +: wait_field_width];
    assign rd_wait   = timing_ctrl_i[rd_wait_lsb +: wait_field_width];
    assign hold_wait = timing_ctrl_i[hold_wait_lsb +: wait_field_width];

    // req is still up during the ack cycle, so that cycle never starts a new access
    assign accept     = (state_q == st_idle) && mem.req && !ack_q;
    assign lower_only = mem.we && (mem.strb[3:2] == 2'b00);

    always_comb
    begin
        case (state_q)
            st_wr_wait1: wait_exit = st_wr_data1;
            st_wr_hold:  wait_exit = st_wr_setup2;
            st_wr_wait2: wait_exit = st_wr_data2;
            st_rd_wait1: wait_exit = st_rd_data1;
            default:     wait_exit = st_rd_data2;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q        <= st_idle;
            wait_q         <= '0;
            ack_q          <= 1'b0;
            sram_oe_o      <= 1'b1;
            sram_we_o      <= 1'b1;
            sram_be_o      <= 2'b11;
            sram_dir_out_o <= 1'b1;
        end
        else
        begin
            ack_q <= 1'b0;
            case (state_q)
                st_idle:
                begin
                    if (accept && mem.we)
                    begin
                        if (mem.strb == 4'b0000)
                            ack_q <= 1'b1;  // nothing to write in either half
                        else
                        begin
                            sram_dir_out_o <= 1'b1;
                            sram_we_o      <= 1'b0;
                            sram_be_o      <= lower_only ? ~mem.strb[1:0] : ~mem.strb[3:2];
                            if (wr_wait != '0)
                            begin
                                wait_q  <= wr_wait;
                                state_q <= lower_only ? st_wr_wait2 : st_wr_wait1;
                            end
                            else
                                state_q <= lower_only ? st_wr_data2 : st_wr_data1;
                        end
                    end
                    else if (accept)
                    begin
                        sram_be_o      <= 2'b00;  // reads always fetch both bytes
                        sram_oe_o      <= 1'b0;
                        sram_dir_out_o <= 1'b0;
                        if (rd_wait != '0)
                        begin
                            wait_q  <= rd_wait;
                            state_q <= st_rd_wait1;
                        end
                        else
                            state_q <= st_rd_data1;
                    end
                    else
                        sram_dir_out_o <= 1'b1;
                end
                st_wr_data1:
                begin
                    sram_we_o <= 1'b1;
                    if (strb_q[1:0] == 2'b00)
                    begin
                        sram_be_o <= 2'b11;
                        ack_q     <= 1'b1;
                        state_q   <= st_idle;
                    end
                    else if (hold_wait != '0)
                    begin
                        wait_q  <= hold_wait;
                        state_q <= st_wr_hold;
                    end
                    else
                        state_q <= st_wr_setup2;
                end
                st_wr_setup2:
                begin
                    sram_be_o <= ~strb_q[1:0];
                    sram_we_o <= 1'b0;
                    if (wr_wait != '0)
                    begin
                        wait_q  <= wr_wait;
                        state_q <= st_wr_wait2;
                    end
                    else
                        state_q <= st_wr_data2;
                end
                st_wr_data2:
                begin
                    sram_we_o <= 1'b1;
                    sram_be_o <= 2'b11;
                    ack_q     <= 1'b1;
                    state_q   <= st_idle;
                end
                st_rd_data1:
                begin
                    if (rd_wait != '0)
                    begin
                        wait_q  <= rd_wait;
                        state_q <= st_rd_wait2;
                    end
                    else
                        state_q <= st_rd_data2;
                end
                st_rd_data2:
                begin
                    sram_oe_o <= 1'b1;
                    sram_be_o <= 2'b11;
                    ack_q     <= 1'b1;
                    state_q   <= st_idle;
                end
                st_wr_wait1, st_wr_hold, st_wr_wait2, st_rd_wait1, st_rd_wait2:
                begin
                    wait_q <= wait_q - 1'b1;
                    if (wait_q == 1)
                        state_q <= wait_exit;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // upper half sits at the even halfword address, lower half at the odd one
    always_ff @(posedge clk_i)
    begin
        case (state_q)
            st_idle:
            begin
                if (accept)
                begin
                    pair_q      <= mem.addr[sram_addr_width:2];
                    wdata_lo_q  <= mem.wdata[15:0];
                    strb_q      <= mem.strb;
                    sram_addr_o <= {mem.addr[sram_addr_width:2], lower_only};
                    sram_data_o <= lower_only ? mem.wdata[15:0] : mem.wdata[31:16];
                end
            end
            st_wr_setup2:
            begin
                sram_addr_o <= {pair_q, 1'b1};
                sram_data_o <= wdata_lo_q;
            end
            st_rd_data1:
            begin
                rd_hi_q     <= sram_data_i;
                sram_addr_o <= {pair_q, 1'b1};
            end
            st_rd_data2: rdata_q <= {rd_hi_q, sram_data_i};  // held until the next read ends
            default: ;
        endcase
    end

    assign mem.ack   = ack_q;
    assign mem.rdata = rdata_q;

    a_oe_we_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        sram_oe_o || sram_we_o);

    // after an ack the arbiter withdraws the request while this side sits in idle
    a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
        mem.ack |=> (state_q == st_idle) && !mem.req);

endmodule

//--- verilog/sram_subsys_top.sv
`timescale 1ns/1ps

module sram_subsys_top
    import sram_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [31:0]                timing_ctrl_i,

    input  logic                       psel0_i,
    input  logic                       penable0_i,
    input  logic                       pwrite0_i,
    input  logic [31:0]                paddr0_i,
    input  logic [31:0]                pwdata0_i,
    input  logic [3:0]                 pstrb0_i,
    output logic [31:0]                prdata0_o,
    output logic                       pready0_o,
    output logic                       pslverr0_o,

    input  logic                       psel1_i,
    input  logic                       penable1_i,
    input  logic                       pwrite1_i,
    input  logic [31:0]                paddr1_i,
    input  logic [31:0]                pwdata1_i,
    input  logic [3:0]                 pstrb1_i,
    output logic [31:0]                prdata1_o,
    output logic                       pready1_o,
    output logic                       pslverr1_o,

    output logic [sram_addr_width-1:0] sram_addr_o,
    output logic [15:0]                sram_data_o,
    input  logic [15:0]                sram_data_i,
    output logic                       sram_oe_o,
    output logic                       sram_we_o,
    output logic [1:0]                 sram_be_o,
    output logic                       sram_dir_out_o
);

    mem_req_if port0_req ();
    mem_req_if port1_req ();
    mem_req_if ctrl_req ();

    apb_mem_port port0_i
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel0_i),
        .penable_i (penable0_i),
        .pwrite_i  (pwrite0_i),
        .paddr_i   (paddr0_i),
        .pwdata_i  (pwdata0_i),
        .pstrb_i   (pstrb0_i),
        .prdata_o  (prdata0_o),
        .pready_o  (pready0_o),
        .pslverr_o (pslverr0_o),
        .mem       (port0_req.requester)
    );

    apb_mem_port port1_i
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel1_i),
        .penable_i (penable1_i),
        .pwrite_i  (pwrite1_i),
        .paddr_i   (paddr1_i),
        .pwdata_i  (pwdata1_i),
        .pstrb_i   (pstrb1_i),
        .prdata_o  (prdata1_o),
        .pready_o  (pready1_o),
        .pslverr_o (pslverr1_o),
        .mem       (port1_req.requester)
    );

    mem_arbiter arbiter_i
    (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req0  (port0_req.server),
        .req1  (port1_req.server),
        .ctrl  (ctrl_req.requester)
    );

    asram16_ctrl ctrl_i
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .timing_ctrl_i  (timing_ctrl_i),
        .sram_addr_o    (sram_addr_o),
        .sram_data_o    (sram_data_o),
        .sram_data_i    (sram_data_i),
        .sram_oe_o      (sram_oe_o),
        .sram_we_o      (sram_we_o),
        .sram_be_o      (sram_be_o),
        .sram_dir_out_o (sram_dir_out_o),
        .mem            (ctrl_req.server)
    );

endmodule

//--- bench/sram_model.sv
`timescale 1ns/1ps

module sram_model
    import sram_pkg::*;
(
    input  logic [sram_addr_width-1:0] addr_i,
    input  logic [15:0]                data_i,
    output logic [15:0]                data_o,
    input  logic                       oe_n_i,
    input  logic                       we_n_i,
    input  logic [1:0]                 be_n_i
);

    logic [15:0]                mem [0:(1 << sram_addr_width) - 1];
    logic [sram_addr_width-1:0] wr_addr;
    logic [15:0]                wr_data;
    logic [1:0]                 wr_be_n;
    logic                       wr_pending;

    initial
        wr_pending = 1'b0;

    // the pins all change on a clock edge, so they are taken just after we falls
    always @(negedge we_n_i)
    begin
        #1;
        wr_addr    = addr_i;
        wr_data    = data_i;
        wr_be_n    = be_n_i;
        wr_pending = 1'b1;
    end

    always @(posedge we_n_i)
    begin
        if (wr_pending)  // data is stored on the rising edge of we
        begin
            if (!wr_be_n[1])
                mem[wr_addr][15:8] = wr_data[15:8];
            if (!wr_be_n[0])
                mem[wr_addr][7:0] = wr_data[7:0];
            wr_pending = 1'b0;
        end
    end

    assign data_o[15:8] = (!oe_n_i && !be_n_i[1]) ? mem[addr_i][15:8] : 8'hxx;
    assign data_o[7:0]  = (!oe_n_i && !be_n_i[0]) ? mem[addr_i][7:0] : 8'hxx;

endmodule

//--- bench/sram_checker.sv
`timescale 1ns/1ps

module sram_checker
    import sram_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [1:0]       psel_i,
    input  logic [1:0]       penable_i,
    input  logic [1:0]       pwrite_i,
    input  logic [1:0][31:0] paddr_i,
    input  logic [1:0][31:0] pwdata_i,
    input  logic [1:0][3:0]  pstrb_i,
    input  logic [1:0][31:0] prdata_i,
    input  logic [1:0]       pready_i,
    input  logic [1:0]       pslverr_i,
    input  logic [1:0][31:0] exp_rdata_i,
    input  logic [1:0]       exp_err_i,
    input  logic [1:0][127:0] test_name_i,
    input  logic             sram_oe_i,
    input  logic             sram_we_i,
    input  logic [1:0]       sram_be_i,
    input  logic             sram_dir_i,
    output int               error_count_o,
    output int               check_count_o
);

    logic [31:0] shadow [0:(sram_byte_limit / 4) - 1];  // word image built from writes
    logic        reset_seen;

    initial
    begin
        error_count_o = 0;
        check_count_o = 0;
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        int          b;
        result = old_word;
        for (b = 0; b < 4; b++)
            if (strb[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        return result;
    endfunction

    task automatic report_mismatch(input logic [127:0] name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        error_count_o = error_count_o + 1;
        $display("Fail %0s %0s expected %h actual %h", name, what, expected, actual);
    endtask

    task automatic check_completion(input int p);
        logic                       in_range;
        logic [sram_addr_width-2:0] word;
        in_range = paddr_i[p] < sram_byte_limit;
        word     = paddr_i[p][sram_addr_width:2];
        check_count_o = check_count_o + 1;
        if (pslverr_i[p] !== exp_err_i[p])
            report_mismatch(test_name_i[p], "pslverr", exp_err_i[p], pslverr_i[p]);
        if (in_range && pwrite_i[p])
            shadow[word] = merge_bytes(shadow[word], pwdata_i[p], pstrb_i[p]);
        else if (in_range)
        begin
            check_count_o = check_count_o + 2;
            if (prdata_i[p] !== shadow[word])
                report_mismatch(test_name_i[p], "shadow", shadow[word], prdata_i[p]);
            if (prdata_i[p] !== exp_rdata_i[p])
                report_mismatch(test_name_i[p], "rdata", exp_rdata_i[p], prdata_i[p]);
        end
    endtask

    always @(posedge clk_i)
    begin
        if (rst_i)
            reset_seen <= 1'b1;
        else if (reset_seen)
        begin
            // values sampled here are still the ones reset left behind
            reset_seen <= 1'b0;
            check_count_o = check_count_o + 2;
            if ({sram_oe_i, sram_we_i, sram_be_i, sram_dir_i} !== 5'b11111)
                report_mismatch("after_reset", "sram_oe_we_be_dir", 32'h1f,
                                {sram_oe_i, sram_we_i, sram_be_i, sram_dir_i});
            if ({pready_i, pslverr_i} !== 4'b0000)
                report_mismatch("after_reset", "pready_pslverr", 32'h0, {pready_i, pslverr_i});
        end
    end

    always @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            for (int p = 0; p < 2; p++)
            begin
                if (pready_i[p] && !(psel_i[p] && penable_i[p]))
                begin
                    error_count_o = error_count_o + 1;
                    $display("protocol error: pready high on port %0d outside an access phase", p);
                end
                else if (pready_i[p])
                    check_completion(p);
            end
        end
    end

endmodule

//--- bench/tb_sram_subsys.sv
`timescale 1ns/1ps

module tb_sram_subsys
    import sram_pkg::*;
();

    localparam int xfer_timeout = 200;  // cycles allowed for one pready

    logic                       clk_i;
    logic                       rst_i;
    logic [31:0]                timing_ctrl;
    logic [1:0]                 psel;
    logic [1:0]                 penable;
    logic [1:0]                 pwrite;
    logic [1:0][31:0]           paddr;
    logic [1:0][31:0]           pwdata;
    logic [1:0][3:0]            pstrb;
    wire  [1:0][31:0]           prdata;
    wire  [1:0]                 pready;
    wire  [1:0]                 pslverr;
    logic [1:0][31:0]           exp_rdata;
    logic [1:0]                 exp_err;
    logic [1:0][127:0]          test_name;
    wire  [sram_addr_width-1:0] sram_addr;
    wire  [15:0]                sram_wdata;
    wire  [15:0]                sram_rdata;
    wire                        sram_oe_n;
    wire                        sram_we_n;
    wire  [1:0]                 sram_be_n;
    wire                        sram_dir;
    int                         error_count;
    int                         check_count;
    int                         timeouts;
    int                         file_errors;

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] timing_word(input int wr, input int rd, input int hold);
        logic [31:0] word;
        word = '0;
        word[wr_wait_lsb +: wait_field_width]   = wr[wait_field_width-1:0];
        word[rd_wait_lsb +: wait_field_width]   = rd[wait_field_width-1:0];
        word[hold_wait_lsb +: wait_field_width] = hold[wait_field_width-1:0];
        return word;
    endfunction

    task automatic apb_transfer(input int port, input int we, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                input int err, input logic [127:0] name);
        int   waited;
        logic done;
        @(posedge clk_i);
        psel[port]      <= 1'b1;
        penable[port]   <= 1'b0;
        pwrite[port]    <= (we != 0);
        paddr[port]     <= addr;
        pwdata[port]    <= (we != 0) ? data : 32'h0;
        pstrb[port]     <= (we != 0) ? strb : 4'h0;
        exp_rdata[port] <= data;
        exp_err[port]   <= (err != 0);
        test_name[port] <= name;
        @(posedge clk_i);
        penable[port] <= 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < xfer_timeout)
        begin
            @(posedge clk_i);
            waited++;
            done = pready[port];
        end
        if (!done)
        begin
            timeouts++;
            $display("timeout: %0s on port %0d saw no pready in %0d cycles", name, port, waited);
        end
        psel[port]    <= 1'b0;
        penable[port] <= 1'b0;
    endtask

    initial
    begin
        int           fd;
        int           fields;
        int           xfer_count;
        int           port, we, wr, rd, hold, err, link;
        int           h_port, h_we, h_err;
        logic         held;
        logic [31:0]  addr, data, h_addr, h_data;
        logic [3:0]   strb, h_strb;
        logic [127:0] name, h_name;
        string        line;
        void'($urandom(8));
        rst_i       = 1'b1;
        timing_ctrl = '0;
        psel        = '0;
        penable     = '0;
        pwrite      = '0;
        paddr       = '0;
        pwdata      = '0;
        pstrb       = '0;
        exp_rdata   = '0;
        exp_err     = '0;
        test_name   = '0;
        timeouts    = 0;
        file_errors = 0;
        xfer_count  = 0;
        held        = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        fd = $fopen("bench/tb_input.txt", "r");
        if (fd == 0)
        begin
            file_errors++;
            $display("could not open the stimulus file bench/tb_input.txt");
        end
        else
        begin
            while (timeouts == 0 && $fgets(line, fd) != 0)
            begin
                fields = $sscanf(line, "%s %d %d %h %h %h %d %d %d %d %d", name, port, we,
                                 addr, data, strb, wr, rd, hold, err, link);
                if (fields == 11)  // comment and blank lines fall through
                begin
                    xfer_count++;
                    if (link != 0 && !held)
                    begin
                        h_name = name;
                        h_port = port;
                        h_we   = we;
                        h_addr = addr;
                        h_data = data;
                        h_strb = strb;
                        h_err  = err;
                        held   = 1'b1;
                    end
                    else
                    begin
                        timing_ctrl <= timing_word(wr, rd, hold);
                        repeat ($urandom % 4) @(posedge clk_i);
                        if (held)
                            fork
                                apb_transfer(h_port, h_we, h_addr, h_data, h_strb, h_err, h_name);
                                apb_transfer(port, we, addr, data, strb, err, name);
                            join
                        else
                            apb_transfer(port, we, addr, data, strb, err, name);
                        held = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (xfer_count == 0)
            begin
                file_errors++;
                $display("no transfers were found in the stimulus file");
            end
        end
        repeat (2) @(posedge clk_i);
        $display("checks %0d, value errors %0d, timeouts %0d, file errors %0d",
                 check_count, error_count, timeouts, file_errors);
        if (error_count == 0 && timeouts == 0 && file_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    sram_subsys_top sram_subsys_top_i
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .timing_ctrl_i  (timing_ctrl),
        .psel0_i        (psel[0]),
        .penable0_i     (penable[0]),
        .pwrite0_i      (pwrite[0]),
        .paddr0_i       (paddr[0]),
        .pwdata0_i      (pwdata[0]),
        .pstrb0_i       (pstrb[0]),
        .prdata0_o      (prdata[0]),
        .pready0_o      (pready[0]),
        .pslverr0_o     (pslverr[0]),
        .psel1_i        (psel[1]),
        .penable1_i     (penable[1]),
        .pwrite1_i      (pwrite[1]),
        .paddr1_i       (paddr[1]),
        .pwdata1_i      (pwdata[1]),
        .pstrb1_i       (pstrb[1]),
        .prdata1_o      (prdata[1]),
        .pready1_o      (pready[1]),
        .pslverr1_o     (pslverr[1]),
        .sram_addr_o    (sram_addr),
        .sram_data_o    (sram_wdata),
        .sram_data_i    (sram_rdata),
        .sram_oe_o      (sram_oe_n),
        .sram_we_o      (sram_we_n),
        .sram_be_o      (sram_be_n),
        .sram_dir_out_o (sram_dir)
    );

    sram_model sram_model_i
    (
        .addr_i (sram_addr),
        .data_i (sram_wdata),
        .data_o (sram_rdata),
        .oe_n_i (sram_oe_n),
        .we_n_i (sram_we_n),
        .be_n_i (sram_be_n)
    );

    sram_checker checker_i
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .pstrb_i       (pstrb),
        .prdata_i      (prdata),
        .pready_i      (pready),
        .pslverr_i     (pslverr),
        .exp_rdata_i   (exp_rdata),
        .exp_err_i     (exp_err),
        .test_name_i   (test_name),
        .sram_oe_i     (sram_oe_n),
        .sram_we_i     (sram_we_n),
        .sram_be_i     (sram_be_n),
        .sram_dir_i    (sram_dir),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

endmodule

//--- bench/tb_input.txt
# name port we addr data strb wr_wait rd_wait hold_wait err link
# data is write data or expected read data, waits are decimal, link 1 starts with the next line
wr_full    0 1 00000100 a1b2c3d4 f 0 0 0 0 0
rd_full    0 0 00000100 a1b2c3d4 0 0 0 0 0 0
wr_init    0 1 00000200 11223344 f 0 0 0 0 0
wr_upper   0 1 00000200 aabbccdd c 0 0 0 0 0
rd_upper   1 0 00000200 aabb3344 0 0 0 0 0 0
wr_lower   1 1 00000200 55667788 3 0 0 0 0 0
rd_lower   0 0 00000200 aabb7788 0 0 0 0 0 0
wr_byte2   0 1 00000200 00ee0000 4 0 0 0 0 0
wr_byte0   1 1 00000200 000000ff 1 0 0 0 0 0
wr_byte3   0 1 00000200 99000000 8 0 0 0 0 0
rd_bytes   1 0 00000200 99ee77ff 0 0 0 0 0 0
wr_waits   0 1 00001000 cafef00d f 3 2 4 0 0
wr_wait_lo 1 1 00001000 00001234 3 5 1 2 0 0
rd_waits   0 0 00001000 cafe1234 0 2 7 1 0 0
rd_slow    1 0 00000100 a1b2c3d4 0 15 15 15 0 0
wr_pair0   0 1 00002000 01234567 f 1 1 1 0 1
wr_pair1   1 1 00002004 89abcdef f 1 1 1 0 0
rd_cross0  0 0 00002004 89abcdef 0 0 0 0 0 1
rd_cross1  1 0 00002000 01234567 0 0 0 0 0 0
wr_zero    1 1 00000000 5a5a0f0f f 0 0 0 0 0
wr_range   0 1 00040000 deadbeef f 0 0 0 1 0
rd_range   1 0 0007fffc 00000000 0 0 0 0 1 0
rd_zero    0 0 00000000 5a5a0f0f 0 0 0 0 0 0

//--- sim.f
verilog/sram_pkg.sv
verilog/mem_req_if.sv
verilog/apb_mem_port.sv
verilog/mem_arbiter.sv
verilog/asram16_ctrl.sv
verilog/sram_subsys_top.sv
bench/sram_model.sv
bench/sram_checker.sv
bench/tb_sram_subsys.sv

//--- Bender.yml
package:
  name: sram_subsys

sources:
  - files:
      - verilog/sram_pkg.sv
      - verilog/mem_req_if.sv
      - verilog/apb_mem_port.sv
      - verilog/mem_arbiter.sv
      - verilog/asram16_ctrl.sv
      - verilog/sram_subsys_top.sv
  - target: test
    files:
      - bench/sram_model.sv
      - bench/sram_checker.sv
      - bench/tb_sram_subsys.sv
